// ==== Makefile ====
TOP := ahb_subsystem_tb

all: run

build:
	verilator --binary --assert -f tb.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim | tee sim.log
	@! grep -q "Testbench failed" sim.log
	@grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== include/ahb_macros.svh ====
`ifndef AHB_MACROS_SVH
`define AHB_MACROS_SVH

// ------------------------------------------------------------
// Bus widths
// ------------------------------------------------------------

// Address and data width of the AHB-Lite bus
`define AHB_ADDR_WIDTH 32
`define AHB_DATA_WIDTH 32

// ------------------------------------------------------------
// Responder map
// ------------------------------------------------------------

// Responder 0 is the SRAM and responder 1 is the register block
`define AHB_NUM_RESP 2

// SRAM depth in words, addresses wrap beyond this
`define AHB_SRAM_WORDS 64

// ------------------------------------------------------------
// Register block
// ------------------------------------------------------------

// Byte offsets inside the register window
`define AHB_REG_SCRATCH 8'h00
`define AHB_REG_ID 8'h04
`define AHB_REG_BLOCKED 8'h08

// Read-only identification word
`define AHB_REG_ID_VALUE 32'hA4B1_0001

`endif

// ==== logic/ahb_lite_address_decoder.sv ====
`default_nettype none

`include "ahb_macros.svh"

module ahb_lite_address_decoder
    import ahb_pkg::*;
(
    input  wire logic                                           hclk,
    input  wire logic                                           hreset_n,

    // Initiator side
    input  wire logic [`AHB_ADDR_WIDTH-1:0]                     haddr_i,
    input  wire logic [`AHB_DATA_WIDTH-1:0]                     hwdata_i,
    input  wire logic                                           hwrite_i,
    input  htrans_e                                             htrans_i,
    input  hsize_e                                              hsize_i,
    output logic [`AHB_DATA_WIDTH-1:0]                          hrdata_o,
    output hresp_e                                              hresp_o,
    output logic                                                hready_o,

    // Address map and disable mask
    input  wire logic [`AHB_NUM_RESP-1:0][`AHB_ADDR_WIDTH-1:0]  resp_start_addr_i,
    input  wire logic [`AHB_NUM_RESP-1:0][`AHB_ADDR_WIDTH-1:0]  resp_end_addr_i,
    input  wire logic [`AHB_NUM_RESP-1:0]                       resp_disable_i,
    output logic [`AHB_NUM_RESP-1:0]                            access_blocked_o,

    // Responder links
    ahb_resp_if.mgr                                             resp [`AHB_NUM_RESP]
);

    // Range hit, hit on a disabled responder and the final select
    logic [`AHB_NUM_RESP-1:0] hit;
    logic [`AHB_NUM_RESP-1:0] blocked;
    logic [`AHB_NUM_RESP-1:0] sel;

    // Select of the transfer that currently owns the data phase
    logic [`AHB_NUM_RESP-1:0] pend_sel;

    // Responses gathered from the links
    logic [`AHB_NUM_RESP-1:0] ready_v;
    logic [`AHB_DATA_WIDTH-1:0] rdata_v [`AHB_NUM_RESP];
    hresp_e resp_v [`AHB_NUM_RESP];

    logic xfer_active;
    logic accept;
    logic err_inject;

    // The injected error runs through two cycles, first stalled then ready
    logic err_first;
    logic err_second;

    // ------------------------------------------------------------
    // Address phase decode
    // ------------------------------------------------------------

    for (genvar g = 0; g < `AHB_NUM_RESP; g++) begin : g_link
        // Inclusive range compare against the map from the top level
        assign hit[g] = (haddr_i >= resp_start_addr_i[g]) && (haddr_i <= resp_end_addr_i[g]);
        assign blocked[g] = hit[g] && resp_disable_i[g];
        assign sel[g] = hit[g] && !resp_disable_i[g];

        // Address phase goes to every link, only hsel differs
        assign resp[g].hsel = sel[g];
        assign resp[g].haddr = haddr_i;
        assign resp[g].hwrite = hwrite_i;
        assign resp[g].htrans = htrans_i;
        assign resp[g].hsize = hsize_i;
        assign resp[g].hwdata = hwdata_i;
        assign resp[g].hready = hready_o;

        assign ready_v[g] = resp[g].hreadyout;
        assign rdata_v[g] = resp[g].hrdata;
        assign resp_v[g] = resp[g].hresp;
    end

    // IDLE and BUSY never reach a responder and always get OKAY
    assign xfer_active = htrans_i inside {NONSEQ, SEQ};
    assign accept = xfer_active && hready_o;

    // Nothing enabled claims the address, so the decoder answers itself
    assign err_inject = accept && !(|sel);

    // ------------------------------------------------------------
    // Registered state
    // ------------------------------------------------------------

    always_ff @(posedge hclk or negedge hreset_n) begin
        if (!hreset_n) begin
            pend_sel <= '0;
            err_first <= 1'b0;
            err_second <= 1'b0;
            access_blocked_o <= '0;
        end else begin
            // The data phase owner only moves on when the bus is ready
            if (hready_o) begin
                pend_sel <= accept ? sel : '0;
            end
            err_first <= err_inject;
            err_second <= err_first;
            // One pulse per accepted transfer that hit a disabled responder
            access_blocked_o <= accept ? blocked : '0;
        end
    end

    // ------------------------------------------------------------
    // Data phase response mux
    // ------------------------------------------------------------

    // With no pending responder the injected error state is returned
    always_comb begin
        hrdata_o = '0;
        hresp_o = (err_first || err_second) ? ERROR : OKAY;
        hready_o = !err_first;
        for (int r = 0; r < `AHB_NUM_RESP; r++) begin
            if (pend_sel[r]) begin
                hrdata_o = rdata_v[r];
                hresp_o = resp_v[r];
                hready_o = ready_v[r];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/ahb_lite_subsystem.sv ====
`default_nettype none

`include "ahb_macros.svh"

module ahb_lite_subsystem
    import ahb_pkg::*;
(
    input  wire logic                                           hclk,
    input  wire logic                                           hreset_n,

    // AHB-Lite initiator port
    input  wire logic [`AHB_ADDR_WIDTH-1:0]                     haddr_i,
    input  wire logic [`AHB_DATA_WIDTH-1:0]                     hwdata_i,
    input  wire logic                                           hwrite_i,
    input  htrans_e                                             htrans_i,
    input  hsize_e                                              hsize_i,
    output logic [`AHB_DATA_WIDTH-1:0]                          hrdata_o,
    output hresp_e                                              hresp_o,
    output logic                                                hready_o,

    // Address map, disable mask and blocked pulses
    input  wire logic [`AHB_NUM_RESP-1:0][`AHB_ADDR_WIDTH-1:0]  resp_start_addr_i,
    input  wire logic [`AHB_NUM_RESP-1:0][`AHB_ADDR_WIDTH-1:0]  resp_end_addr_i,
    input  wire logic [`AHB_NUM_RESP-1:0]                       resp_disable_i,
    output logic [`AHB_NUM_RESP-1:0]                            access_blocked_o
);

    // One link per responder, index 0 is the SRAM and index 1 the registers
    ahb_resp_if u_link [`AHB_NUM_RESP] ();

    ahb_lite_address_decoder u_decoder (
        .hclk              (hclk),
        .hreset_n          (hreset_n),
        .haddr_i           (haddr_i),
        .hwdata_i          (hwdata_i),
        .hwrite_i          (hwrite_i),
        .htrans_i          (htrans_i),
        .hsize_i           (hsize_i),
        .hrdata_o          (hrdata_o),
        .hresp_o           (hresp_o),
        .hready_o          (hready_o),
        .resp_start_addr_i (resp_start_addr_i),
        .resp_end_addr_i   (resp_end_addr_i),
        .resp_disable_i    (resp_disable_i),
        .access_blocked_o  (access_blocked_o),
        .resp              (u_link)
    );

    ahb_sram_responder u_sram (
        .hclk     (hclk),
        .hreset_n (hreset_n),
        .bus      (u_link[0])
    );

    // Blocked pulses feed the counter as well as the top-level output
    ahb_reg_responder u_regs (
        .hclk             (hclk),
        .hreset_n         (hreset_n),
        .bus              (u_link[1]),
        .access_blocked_i (access_blocked_o)
    );

endmodule

`default_nettype wire

// ==== logic/ahb_pkg.sv ====
`default_nettype none

`include "ahb_macros.svh"

package ahb_pkg;

    // ------------------------------------------------------------
    // AHB-Lite encodings
    // ------------------------------------------------------------

    // Transfer type driven by the initiator on HTRANS
    // SEQ is accepted but handled as a single beat, bursts are not modelled
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // Transfer size on HSIZE
    // Only the sizes that fit in a 32-bit data bus are listed
    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_e;

    // Single-bit AHB-Lite response
    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_e;

    // ------------------------------------------------------------
    // Interconnect types
    // ------------------------------------------------------------

    // Index of one responder behind the decoder
    typedef logic [$clog2(`AHB_NUM_RESP)-1:0] resp_idx_t;

endpackage

`default_nettype wire

// ==== logic/ahb_reg_responder.sv ====
`default_nettype none

`include "ahb_macros.svh"

module ahb_reg_responder
    import ahb_pkg::*;
(
    input  wire logic                     hclk,
    input  wire logic                     hreset_n,
    ahb_resp_if.sub                       bus,
    input  wire logic [`AHB_NUM_RESP-1:0] access_blocked_i
);

    // Links whose blocked pulses are counted
    localparam resp_idx_t SRAM_IDX = resp_idx_t'(0);
    localparam resp_idx_t REG_IDX = resp_idx_t'(1);

    logic accept;
    logic [7:0] ofs;
    logic bad_access;
    logic blk_event;
    logic wr_commit;

    // Offset of the transfer in its data phase
    logic [7:0] ofs_q;

    logic wr_pend;
    logic err_first;
    logic err_second;

    // Software visible registers
    logic [`AHB_DATA_WIDTH-1:0] scratch_q;
    logic [`AHB_DATA_WIDTH-1:0] blocked_cnt_q;

    assign accept = bus.hsel && bus.hready && (bus.htrans inside {NONSEQ, SEQ});
    assign ofs = bus.haddr[7:0];

    // Unknown offsets and writes to the read-only ID are refused
    assign bad_access = !(ofs inside {`AHB_REG_SCRATCH, `AHB_REG_ID, `AHB_REG_BLOCKED}) ||
                        (bus.hwrite && (ofs == `AHB_REG_ID));

    assign blk_event = access_blocked_i[SRAM_IDX] || access_blocked_i[REG_IDX];
    assign wr_commit = wr_pend && bus.hready;

    // ------------------------------------------------------------
    // Transfer control
    // ------------------------------------------------------------

    always_ff @(posedge hclk or negedge hreset_n) begin
        if (!hreset_n) begin
            wr_pend <= 1'b0;
            err_first <= 1'b0;
            err_second <= 1'b0;
        end else begin
            if (bus.hready) begin
                wr_pend <= accept && bus.hwrite && !bad_access;
            end
            // Two-cycle error, stalled first and then completed
            err_first <= accept && bad_access;
            err_second <= err_first;
        end
    end

    always_ff @(posedge hclk) begin
        if (accept) begin
            ofs_q <= ofs;
        end
    end

    // ------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------

    always_ff @(posedge hclk or negedge hreset_n) begin
        if (!hreset_n) begin
            scratch_q <= '0;
            blocked_cnt_q <= '0;
        end else begin
            // Whole word is taken whatever the transfer size
            if (wr_commit && (ofs_q == `AHB_REG_SCRATCH)) begin
                scratch_q <= bus.hwdata;
            end
            // A write to the counter clears it and wins over a new event
            if (wr_commit && (ofs_q == `AHB_REG_BLOCKED)) begin
                blocked_cnt_q <= '0;
            end else if (blk_event && (blocked_cnt_q != '1)) begin
                blocked_cnt_q <= blocked_cnt_q + 1'b1;
            end
        end
    end

    // Read data from the registered offset, so a write just before is visible
    always_comb begin
        case (ofs_q)
            `AHB_REG_SCRATCH: bus.hrdata = scratch_q;
            `AHB_REG_ID:      bus.hrdata = `AHB_REG_ID_VALUE;
            `AHB_REG_BLOCKED: bus.hrdata = blocked_cnt_q;
            default:          bus.hrdata = '0;
        endcase
    end

    assign bus.hreadyout = !err_first;
    assign bus.hresp = (err_first || err_second) ? ERROR : OKAY;

endmodule

`default_nettype wire

// ==== logic/ahb_resp_if.sv ====
`default_nettype none

`include "ahb_macros.svh"

// One decoder-to-responder link of the AHB-Lite interconnect
interface ahb_resp_if
    import ahb_pkg::*;
();

    // Address phase and write data, driven by the decoder
    logic                        hsel;
    logic [`AHB_ADDR_WIDTH-1:0]  haddr;
    logic                        hwrite;
    htrans_e                     htrans;
    hsize_e                      hsize;
    logic [`AHB_DATA_WIDTH-1:0]  hwdata;

    // Global ready returned to every responder
    logic                        hready;

    // Data-phase response, driven by the responder
    logic                        hreadyout;
    logic [`AHB_DATA_WIDTH-1:0]  hrdata;
    hresp_e                      hresp;

    // Decoder side
    modport mgr (
        output hsel, haddr, hwrite, htrans, hsize, hwdata, hready,
        input  hreadyout, hrdata, hresp
    );

    // Responder side
    modport sub (
        input  hsel, haddr, hwrite, htrans, hsize, hwdata, hready,
        output hreadyout, hrdata, hresp
    );

endinterface

`default_nettype wire

// ==== logic/ahb_sram_responder.sv ====
`default_nettype none

`include "ahb_macros.svh"

module ahb_sram_responder
    import ahb_pkg::*;
(
    input  wire logic hclk,
    input  wire logic hreset_n,
    ahb_resp_if.sub   bus
);

    localparam int IDX_W = $clog2(`AHB_SRAM_WORDS);
    localparam int LANES = `AHB_DATA_WIDTH / 8;

    // Word array, byte lanes are merged on write
    logic [`AHB_DATA_WIDTH-1:0] mem [`AHB_SRAM_WORDS];

    logic accept;
    logic [LANES-1:0] lane_sel;

    // Address phase captured for the data phase
    logic [IDX_W-1:0] idx_q;
    logic [LANES-1:0] lanes_q;
    logic [`AHB_DATA_WIDTH-1:0] rdata_q;

    // A write in its data phase and the single read wait state
    logic wr_pend;
    logic rd_wait;

    assign accept = bus.hsel && bus.hready && (bus.htrans inside {NONSEQ, SEQ});

    // ------------------------------------------------------------
    // Byte lane select
    // ------------------------------------------------------------

    // Little-endian lanes from the size and the low address bits
    always_comb begin
        case (bus.hsize)
            BYTE:    lane_sel = LANES'(1) << bus.haddr[1:0];
            HALF:    lane_sel = LANES'(3) << {bus.haddr[1], 1'b0};
            default: lane_sel = {LANES{1'b1}};
        endcase
    end

    // ------------------------------------------------------------
    // Control
    // ------------------------------------------------------------

    always_ff @(posedge hclk or negedge hreset_n) begin
        if (!hreset_n) begin
            wr_pend <= 1'b0;
            rd_wait <= 1'b0;
        end else begin
            if (bus.hready) begin
                wr_pend <= accept && bus.hwrite;
            end
            // Bus is stalled during the wait, so this clears after one cycle
            rd_wait <= accept && !bus.hwrite;
        end
    end

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------

    always_ff @(posedge hclk) begin
        if (accept) begin
            // Index from the bits above bit 1, wraps modulo the depth
            idx_q <= bus.haddr[2 +: IDX_W];
            lanes_q <= lane_sel;
        end
        // Write data belongs to the data phase and lands at its end
        if (wr_pend && bus.hready) begin
            for (int l = 0; l < LANES; l++) begin
                if (lanes_q[l]) begin
                    mem[idx_q][8*l +: 8] <= bus.hwdata[8*l +: 8];
                end
            end
        end
        // Read the array during the wait state, data shows next cycle
        if (rd_wait) begin
            rdata_q <= mem[idx_q];
        end
    end

    assign bus.hreadyout = !rd_wait;
    assign bus.hrdata = rdata_q;
    assign bus.hresp = OKAY;

endmodule

`default_nettype wire

// ==== sim/ahb_subsystem_sva.sv ====
`default_nettype none

`include "ahb_macros.svh"

// Protocol properties on the initiator port of the interconnect
module ahb_subsystem_sva
    import ahb_pkg::*;
(
    input  wire logic                     hclk,
    input  wire logic                     hreset_n,
    input  wire logic                     hready_o,
    input  hresp_e                        hresp_o,
    input  wire logic [`AHB_NUM_RESP-1:0] access_blocked_o
);

    // The bus idles ready while reset is held
    a_ready_in_reset: assert property (@(posedge hclk) !hreset_n |-> hready_o)
        else $error("hready_o low during reset");

    // ------------------------------------------------------------
    // Error response shape
    // ------------------------------------------------------------

    // Completing ERROR cycle follows a stalled ERROR cycle
    a_error_two_cycle: assert property (@(posedge hclk) disable iff (!hreset_n)
        ((hresp_o == ERROR) && hready_o) |-> $past((hresp_o == ERROR) && !hready_o))
        else $error("ERROR completed without a stalled first cycle");

    // Only one responder can be blocked by a single transfer
    a_blocked_onehot: assert property (@(posedge hclk) disable iff (!hreset_n)
        $onehot0(access_blocked_o))
        else $error("access_blocked_o has more than one bit set");

endmodule

bind ahb_lite_subsystem ahb_subsystem_sva u_sva (
    .hclk             (hclk),
    .hreset_n         (hreset_n),
    .hready_o         (hready_o),
    .hresp_o          (hresp_o),
    .access_blocked_o (access_blocked_o)
);

`default_nettype wire

// ==== sim/ahb_subsystem_tb.sv ====
`default_nettype none

`include "ahb_macros.svh"

module ahb_subsystem_tb
    import ahb_pkg::*;
();

    // Longest wait in cycles before a stalled bus counts as hung
    localparam int TIMEOUT = 20;

    // Address map used for this run with everything else unmapped
    localparam logic [31:0] SRAM_LAST = 32'h0000_00FF;
    localparam logic [31:0] REG_FIRST = 32'h0001_0000;
    localparam logic [31:0] REG_LAST = 32'h0001_000F;

    logic hclk = 1'b0;
    logic hreset_n;
    logic [`AHB_ADDR_WIDTH-1:0] haddr;
    logic [`AHB_DATA_WIDTH-1:0] hwdata;
    logic hwrite;
    htrans_e htrans;
    hsize_e hsize;
    logic [`AHB_DATA_WIDTH-1:0] hrdata;
    hresp_e hresp;
    logic hready;
    logic [`AHB_NUM_RESP-1:0][`AHB_ADDR_WIDTH-1:0] start_addr;
    logic [`AHB_NUM_RESP-1:0][`AHB_ADDR_WIDTH-1:0] end_addr;
    logic [`AHB_NUM_RESP-1:0] resp_disable;
    logic [`AHB_NUM_RESP-1:0] access_blocked;

    // Reference model state
    logic [31:0] shadow [`AHB_SRAM_WORDS];
    logic [31:0] scratch_model;
    logic [31:0] blk_count;
    logic [`AHB_NUM_RESP-1:0] disable_model;

    logic [31:0] rng_state;
    int error_count;
    int xfer_count;

    always #20 hclk = ~hclk;

    ahb_lite_subsystem u_dut (
        .hclk              (hclk),
        .hreset_n          (hreset_n),
        .haddr_i           (haddr),
        .hwdata_i          (hwdata),
        .hwrite_i          (hwrite),
        .htrans_i          (htrans),
        .hsize_i           (hsize),
        .hrdata_o          (hrdata),
        .hresp_o           (hresp),
        .hready_o          (hready),
        .resp_start_addr_i (start_addr),
        .resp_end_addr_i   (end_addr),
        .resp_disable_i    (resp_disable),
        .access_blocked_o  (access_blocked)
    );

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Little-endian byte lanes picked by the size and the low address bits
    function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] wdata,
                                                input hsize_e sz, input logic [1:0] a);
        logic [31:0] res;
        res = old;
        case (sz)
            BYTE:    res[8*a +: 8] = wdata[8*a +: 8];
            HALF:    res[16*a[1] +: 16] = wdata[16*a[1] +: 16];
            default: res = wdata;
        endcase
        return res;
    endfunction

    task automatic log_mismatch(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout: hready_o stayed low too long in the %s at time %0t", what, $time);
        $display("Testbench failed");
        $finish;
    endtask

    // Model the new disable mask together with the driven one
    task automatic set_disable(input logic [`AHB_NUM_RESP-1:0] mask);
        @(posedge hclk);
        resp_disable <= mask;
        disable_model = mask;
    endtask

    // ------------------------------------------------------------
    // One transfer with its expected answer from the model
    // ------------------------------------------------------------

    task automatic run_xfer(input htrans_e tr, input logic wr, input hsize_e sz,
                            input logic [31:0] addr, input logic [31:0] wdata);
        logic active;
        logic in_sram;
        logic in_reg;
        logic exp_err;
        logic check_rdata;
        logic [31:0] exp_rdata;
        logic [`AHB_NUM_RESP-1:0] exp_blk;
        logic [`AHB_NUM_RESP-1:0] blk_seen;
        logic [7:0] ofs;
        int exp_wait;
        int n_wait;
        int guard;
        hresp_e first_resp;
        active = (tr == NONSEQ) || (tr == SEQ);
        in_sram = addr <= SRAM_LAST;
        in_reg = (addr >= REG_FIRST) && (addr <= REG_LAST);
        ofs = addr[7:0];
        exp_err = 1'b0;
        check_rdata = 1'b0;
        exp_rdata = '0;
        exp_blk = '0;
        exp_wait = 0;
        if (active) begin
            if (in_sram && disable_model[0]) begin
                exp_err = 1'b1;
                exp_blk = 2'b01;
            end else if (in_sram && !wr) begin
                // One wait state before the word comes back
                exp_wait = 1;
                check_rdata = 1'b1;
                exp_rdata = shadow[addr[7:2]];
            end else if (in_reg) begin
                // Three known offsets and the ID refuses writes
                case (ofs)
                    `AHB_REG_SCRATCH: exp_rdata = scratch_model;
                    `AHB_REG_ID: begin
                        exp_rdata = `AHB_REG_ID_VALUE;
                        exp_err = wr;
                    end
                    `AHB_REG_BLOCKED: exp_rdata = blk_count;
                    default:          exp_err = 1'b1;
                endcase
                check_rdata = !wr && !exp_err;
            end else if (!in_sram) begin
                exp_err = 1'b1;
            end
            if (exp_err) begin
                exp_wait = 1;
            end
        end

        // Address phase is held until the bus is ready
        @(posedge hclk);
        haddr <= addr;
        htrans <= tr;
        hwrite <= wr;
        hsize <= sz;
        guard = 0;
        @(negedge hclk);
        while (!hready) begin
            guard++;
            if (guard > TIMEOUT) begin
                abort_on_timeout("address phase");
            end
            @(negedge hclk);
        end

        // Accepted on this edge and write data follows in the data phase
        @(posedge hclk);
        htrans <= IDLE;
        hwdata <= wdata;
        n_wait = 0;
        first_resp = OKAY;
        @(negedge hclk);
        blk_seen = access_blocked;
        while (!hready) begin
            n_wait++;
            if (n_wait == 1) begin
                first_resp = hresp;
            end
            if (n_wait > TIMEOUT) begin
                abort_on_timeout("data phase");
            end
            @(negedge hclk);
        end
        xfer_count++;

        if (n_wait != exp_wait) begin
            log_mismatch($sformatf("%0d wait cycles, expected %0d, address 0x%08h",
                                   n_wait, exp_wait, addr));
        end
        if (exp_err && ((first_resp != ERROR) || (hresp != ERROR))) begin
            log_mismatch($sformatf("no two-cycle ERROR at address 0x%08h", addr));
        end
        if (!exp_err && (hresp != OKAY)) begin
            log_mismatch($sformatf("unexpected ERROR at address 0x%08h", addr));
        end
        if (check_rdata && (hrdata !== exp_rdata)) begin
            log_mismatch($sformatf("read 0x%08h, expected 0x%08h, address 0x%08h",
                                   hrdata, exp_rdata, addr));
        end
        if (blk_seen !== exp_blk) begin
            log_mismatch($sformatf("blocked pulse %b, expected %b", blk_seen, exp_blk));
        end

        // Completed writes and blocked hits update the model
        if (active && !exp_err && wr && in_sram) begin
            shadow[addr[7:2]] = merge_lanes(shadow[addr[7:2]], wdata, sz, addr[1:0]);
        end
        if (active && !exp_err && wr && in_reg && (ofs == `AHB_REG_SCRATCH)) begin
            scratch_model = wdata;
        end
        if (active && !exp_err && wr && in_reg && (ofs == `AHB_REG_BLOCKED)) begin
            blk_count = '0;
        end
        if (exp_blk[0]) begin
            blk_count = blk_count + 1;
        end
    endtask

    // Random mix of SRAM, register, unmapped and idle transfers
    task automatic random_op();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] wdata;
        logic [31:0] addr;
        htrans_e tr;
        hsize_e sz;
        r = xorshift32();
        a = xorshift32();
        wdata = xorshift32();
        tr = r[3] ? SEQ : NONSEQ;
        sz = (r[5:4] == 2'd0) ? BYTE : ((r[5:4] == 2'd1) ? HALF : WORD);
        case (sz)
            BYTE:    addr = {24'h0, a[7:0]};
            HALF:    addr = {24'h0, a[7:1], 1'b0};
            default: addr = {24'h0, a[7:2], 2'b00};
        endcase
        case (r[2:0])
            3'd0, 3'd1, 3'd2: run_xfer(tr, 1'b1, sz, addr, wdata);
            3'd3, 3'd4:       run_xfer(tr, 1'b0, WORD, {24'h0, a[7:2], 2'b00}, wdata);
            // Offset 0xC is outside the register set
            3'd5:             run_xfer(tr, r[6], WORD, {16'h0001, 12'h000, a[3:2], 2'b00}, wdata);
            3'd6: begin
                addr = r[7] ? (32'h0001_0010 + {20'h0, a[11:0]}) : (32'h0002_0000 | a);
                run_xfer(tr, r[6], WORD, addr, wdata);
            end
            default:          run_xfer(r[3] ? BUSY : IDLE, r[6], WORD, 32'h0002_0000 | a, wdata);
        endcase
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------

    initial begin
        hreset_n = 1'b0;
        haddr = '0;
        hwdata = '0;
        hwrite = 1'b0;
        htrans = IDLE;
        hsize = WORD;
        start_addr[0] = 32'h0000_0000;
        end_addr[0] = SRAM_LAST;
        start_addr[1] = REG_FIRST;
        end_addr[1] = REG_LAST;
        resp_disable = '0;
        disable_model = '0;
        scratch_model = '0;
        blk_count = '0;
        rng_state = 32'hef62;
        error_count = 0;
        xfer_count = 0;

        repeat (16) begin
            @(negedge hclk);
            if (hready !== 1'b1) begin
                log_mismatch("hready_o low during reset");
            end
        end
        @(posedge hclk);
        hreset_n <= 1'b1;

        // Fill every SRAM word, then read all of them back
        for (int i = 0; i < `AHB_SRAM_WORDS; i++) begin
            run_xfer(NONSEQ, 1'b1, WORD, 32'(i * 4), xorshift32());
        end
        for (int i = 0; i < `AHB_SRAM_WORDS; i++) begin
            run_xfer(NONSEQ, 1'b0, WORD, 32'(i * 4), '0);
        end

        repeat (300) random_op();

        // With the SRAM masked off its accesses are blocked and counted
        set_disable(2'b01);
        repeat (80) random_op();
        set_disable(2'b00);

        // Shadow contents must have survived the blocked writes
        for (int i = 0; i < `AHB_SRAM_WORDS; i++) begin
            run_xfer(NONSEQ, 1'b0, WORD, 32'(i * 4), '0);
        end

        run_xfer(NONSEQ, 1'b0, WORD, REG_FIRST | 32'(`AHB_REG_ID), '0);
        run_xfer(NONSEQ, 1'b1, WORD, REG_FIRST | 32'(`AHB_REG_SCRATCH), 32'h5A5A_0F0F);
        run_xfer(NONSEQ, 1'b0, WORD, REG_FIRST | 32'(`AHB_REG_SCRATCH), '0);
        run_xfer(NONSEQ, 1'b0, WORD, REG_FIRST | 32'(`AHB_REG_BLOCKED), '0);
        run_xfer(NONSEQ, 1'b1, WORD, REG_FIRST | 32'(`AHB_REG_BLOCKED), '0);
        run_xfer(NONSEQ, 1'b0, WORD, REG_FIRST | 32'(`AHB_REG_BLOCKED), '0);
        @(posedge hclk);

        $display("Run complete: %0d transfers, %0d errors", xfer_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
logic/ahb_pkg.sv
logic/ahb_resp_if.sv
logic/ahb_lite_address_decoder.sv
logic/ahb_sram_responder.sv
logic/ahb_reg_responder.sv
logic/ahb_lite_subsystem.sv
sim/ahb_subsystem_sva.sv
sim/ahb_subsystem_tb.sv
